// File: verilog/timingPkg.sv
// raster timing constants for the 640x480 style frame on clk25
// counter width, totals, sync, blank and border windows, sync polarity
`default_nettype none

package timingPkg;

  localparam int ctrWidth = 12;                      // raster counter width

  // horizontal, in clk25 cycles
  localparam logic [ctrWidth-1:0] hTotal     = 12'd800;  // last count before wrap
  localparam logic [ctrWidth-1:0] hSyncOn    = 12'd16;
  localparam logic [ctrWidth-1:0] hSyncOff   = 12'd112;  // exclusive
  localparam logic [ctrWidth-1:0] hBlankOff  = 12'd160;  // end of back porch
  localparam logic [ctrWidth-1:0] hBorderOff = 12'd168;
  localparam logic [ctrWidth-1:0] hBorderOn  = 12'd792;

  // vertical, in lines
  localparam logic [ctrWidth-1:0] vTotal     = 12'd525;
  localparam logic [ctrWidth-1:0] vSyncOn    = 12'd10;
  localparam logic [ctrWidth-1:0] vSyncOff   = 12'd12;   // exclusive
  localparam logic [ctrWidth-1:0] vBlankOff  = 12'd45;
  localparam logic [ctrWidth-1:0] vBorderOff = 12'd49;
  localparam logic [ctrWidth-1:0] vBorderOn  = 12'd521;

  // 1 gives a low pulse inside the sync window
  localparam logic hSyncPol = 1'b1;
  localparam logic vSyncPol = 1'b1;

endpackage

`default_nettype wire

// File: verilog/regMapPkg.sv
// CPU register map of the video controller
// address width, register addresses, colour width, interrupt bits
`default_nettype none

package regMapPkg;

  localparam int regAddrWidth = 7;                   // byte register space
  localparam int colorWidth   = 6;                   // 2 bits each of r, g, b
  localparam int irqWidth     = 4;                   // flag and enable bits

  //------------------------------------------------------------
  // register addresses
  //------------------------------------------------------------
  localparam logic [regAddrWidth-1:0] addrRasterLo = 7'h5E;  // raster line / compare
  localparam logic [regAddrWidth-1:0] addrRasterHi = 7'h5F;
  localparam logic [regAddrWidth-1:0] addrLpxLo    = 7'h60;  // light pen x
  localparam logic [regAddrWidth-1:0] addrLpxHi    = 7'h61;
  localparam logic [regAddrWidth-1:0] addrLpyLo    = 7'h62;  // light pen y
  localparam logic [regAddrWidth-1:0] addrLpyHi    = 7'h63;
  localparam logic [regAddrWidth-1:0] addrIrqStat  = 7'h65;  // status, write 1 to clear
  localparam logic [regAddrWidth-1:0] addrIrqEn    = 7'h66;
  localparam logic [regAddrWidth-1:0] addrExtColor = 7'h67;  // exterior colour
  localparam logic [regAddrWidth-1:0] addrBgColor  = 7'h68;  // background colour 0

  // bit positions in status and enable
  localparam int irqRstBit = 0;                      // raster compare
  localparam int irqLpBit  = 3;                      // light pen

  // read value of an unmapped address
  localparam logic [7:0] unusedRead = 8'hFF;

endpackage

`default_nettype wire

// File: verilog/rasterTiming.sv
// raster timing generator
// chained horizontal and vertical counters
// registered hSync, vSync, blank and border flags
`timescale 1ns/1ps
`default_nettype none

module rasterTiming
  import timingPkg::*;
(
  input  wire                 clk25,
  input  wire                 rst,
  output logic [ctrWidth-1:0] hCtr,
  output logic [ctrWidth-1:0] vCtr,
  output logic                hSync,
  output logic                vSync,
  output logic                blank,
  output logic                border
);

  logic eol;                                         // last clock of a line
  logic eof;                                         // last clock of a frame
  logic hSyncNext, vSyncNext;
  logic hBlank, vBlank;
  logic hBorder, vBorder;

  assign eol = (hCtr == hTotal);
  assign eof = eol && (vCtr == vTotal);

  //------------------------------------------------------------
  // counters
  //------------------------------------------------------------
  always_ff @(posedge clk25) begin
    if (rst) begin
      hCtr <= '0;
      vCtr <= '0;
    end else begin
      if (eol)
        hCtr <= 12'd1;                               // lines count from 1
      else
        hCtr <= hCtr + 12'd1;
      if (eof)
        vCtr <= 12'd1;
      else if (eol)
        vCtr <= vCtr + 12'd1;
    end
  end

  //------------------------------------------------------------
  // window decode
  //------------------------------------------------------------
  assign hSyncNext = (hCtr >= hSyncOn && hCtr < hSyncOff) ^ hSyncPol;
  assign vSyncNext = (vCtr >= vSyncOn && vCtr < vSyncOff) ^ vSyncPol;
  assign hBlank    = (hCtr >= hTotal) || (hCtr < hBlankOff);
  assign vBlank    = (vCtr >= vTotal) || (vCtr < vBlankOff);
  assign hBorder   = (hCtr >= hBorderOn) || (hCtr < hBorderOff);
  assign vBorder   = (vCtr >= vBorderOn) || (vCtr < vBorderOff);

  // all four flags on one edge so they stay aligned
  always_ff @(posedge clk25) begin
    if (rst) begin
      hSync  <= hSyncPol;                            // inactive level
      vSync  <= vSyncPol;
      blank  <= 1'b1;
      border <= 1'b1;
    end else begin
      hSync  <= hSyncNext;
      vSync  <= vSyncNext;
      blank  <= hBlank | vBlank;
      border <= hBorder | vBorder;                   // blank region is inside border
    end
  end

  // counters wrap at their totals
  hCtrRange: assert property (@(posedge clk25) disable iff (rst)
    hCtr <= hTotal);
  vCtrRange: assert property (@(posedge clk25) disable iff (rst)
    vCtr <= vTotal);

endmodule

`default_nettype wire

// File: verilog/vicRegs.sv
// CPU register block
// write decode for raster compare, irq enable and colours
// clear strobes for the interrupt flags, registered read-back mux
`timescale 1ns/1ps
`default_nettype none

module vicRegs
  import timingPkg::*, regMapPkg::*;
(
  input  wire                     clk25,
  input  wire                     rst,
  // CPU side
  input  wire                     cs,
  input  wire                     we,
  input  wire  [regAddrWidth-1:0] addr,
  input  wire  [7:0]              wrData,
  output logic [7:0]              rdData,
  // from timing and interrupt blocks
  input  wire  [ctrWidth-1:0]     vCtr,
  input  wire  [irqWidth-1:0]     irqFlags,
  input  wire                     irq,
  input  wire  [ctrWidth-1:0]     lpx,
  input  wire  [ctrWidth-1:0]     lpy,
  // to the other blocks
  output logic [ctrWidth-1:0]     rasterCmp,
  output logic [irqWidth-1:0]     irqEnable,
  output logic                    rstClr,
  output logic                    lpClr,
  output logic [colorWidth-1:0]   extColor,
  output logic [colorWidth-1:0]   bgColor
);

  logic                wrStb;                        // write cycle
  logic                rdStb;                        // read cycle
  logic [ctrWidth-9:0] vCtrHi;                       // latched on a low byte read
  logic [7:0]          rdMux;

  assign wrStb = cs && we;
  assign rdStb = cs && !we;

  //------------------------------------------------------------
  // writes
  //------------------------------------------------------------
  always_ff @(posedge clk25) begin
    if (rst) begin
      rasterCmp <= '0;
      irqEnable <= '0;
      extColor  <= '0;
      bgColor   <= '0;
      rstClr    <= 1'b0;
      lpClr     <= 1'b0;
    end else begin
      // strobes last one cycle
      rstClr <= wrStb && (addr == addrIrqStat) && wrData[irqRstBit];
      lpClr  <= wrStb && (addr == addrIrqStat) && wrData[irqLpBit];
      if (wrStb) begin
        case (addr)
          addrRasterLo: rasterCmp[7:0]          <= wrData;
          addrRasterHi: rasterCmp[ctrWidth-1:8] <= wrData[ctrWidth-9:0];
          addrIrqEn:    irqEnable               <= wrData[irqWidth-1:0];
          addrExtColor: extColor                <= wrData[colorWidth-1:0];
          addrBgColor:  bgColor                 <= wrData[colorWidth-1:0];
          default: ;                                 // read only or unmapped
        endcase
      end
    end
  end

  //------------------------------------------------------------
  // read-back
  //------------------------------------------------------------
  always_comb begin
    case (addr)
      addrRasterLo: rdMux = vCtr[7:0];
      addrRasterHi: rdMux = {{(16 - ctrWidth){1'b0}}, vCtrHi};
      addrLpxLo:    rdMux = lpx[7:0];
      addrLpxHi:    rdMux = {{(16 - ctrWidth){1'b0}}, lpx[ctrWidth-1:8]};
      addrLpyLo:    rdMux = lpy[7:0];
      addrLpyHi:    rdMux = {{(16 - ctrWidth){1'b0}}, lpy[ctrWidth-1:8]};
      addrIrqStat:  rdMux = {irq, 3'b111, irqFlags};  // irq on top
      addrIrqEn:    rdMux = {{(8 - irqWidth){1'b0}}, irqEnable};
      addrExtColor: rdMux = {{(8 - colorWidth){1'b0}}, extColor};
      addrBgColor:  rdMux = {{(8 - colorWidth){1'b0}}, bgColor};
      default:      rdMux = unusedRead;
    endcase
  end

  // high bits held so a two byte read sees one line value
  always_ff @(posedge clk25) begin
    if (rst)
      vCtrHi <= '0;
    else if (rdStb && addr == addrRasterLo)
      vCtrHi <= vCtr[ctrWidth-1:8];
  end

  always_ff @(posedge clk25) begin
    if (rdStb)
      rdData <= rdMux;                               // valid next cycle, held
  end

endmodule

`default_nettype wire

// File: verilog/interruptUnit.sv
// interrupt unit
// raster compare with one hit per frame, light pen position latch
// flag bits with clear strobes and the masked irq output
`timescale 1ns/1ps
`default_nettype none

module interruptUnit
  import timingPkg::*, regMapPkg::*;
(
  input  wire                 clk25,
  input  wire                 rst,
  input  wire  [ctrWidth-1:0] hCtr,
  input  wire  [ctrWidth-1:0] vCtr,
  input  wire  [ctrWidth-1:0] rasterCmp,
  input  wire  [irqWidth-1:0] irqEnable,
  input  wire                 rstClr,
  input  wire                 lpClr,
  input  wire                 lpN,
  output logic [irqWidth-1:0] irqFlags,
  output logic                irq,
  output logic [ctrWidth-1:0] lpx,
  output logic [ctrWidth-1:0] lpy
);

  logic rasterDone;                                  // compare fired this frame
  logic rasterHit;
  logic lpHit;                                       // pen already latched
  logic lpTake;
  logic flagRst, flagLp;

  // line 0 only exists right after reset
  assign rasterHit = !rasterDone && (vCtr == rasterCmp) && (vCtr != 12'd0);
  assign lpTake    = !lpHit && !lpN && (vCtr != 12'd0);

  //------------------------------------------------------------
  // raster compare
  //------------------------------------------------------------
  always_ff @(posedge clk25) begin
    if (rst) begin
      rasterDone <= 1'b0;
      flagRst    <= 1'b0;
    end else begin
      if (rasterHit)
        rasterDone <= 1'b1;
      else if ((vCtr == 12'd0 || vCtr == 12'd1) && hCtr == 12'd1)
        rasterDone <= 1'b0;                          // rearm at top of frame
      if (rasterHit)
        flagRst <= 1'b1;                             // new hit beats a clear
      else if (rstClr)
        flagRst <= 1'b0;
    end
  end

  //------------------------------------------------------------
  // light pen
  //------------------------------------------------------------
  always_ff @(posedge clk25) begin
    if (rst) begin
      lpHit  <= 1'b0;
      flagLp <= 1'b0;
      lpx    <= '0;
      lpy    <= '0;
    end else begin
      if (vCtr == 12'd0)
        lpHit <= 1'b0;
      else if (lpTake) begin
        lpHit <= 1'b1;
        lpx   <= hCtr;                               // beam position before edge
        lpy   <= vCtr;
      end
      if (lpTake)
        flagLp <= 1'b1;
      else if (lpClr)
        flagLp <= 1'b0;
    end
  end

  // bits 1 and 2 have no source here
  always_comb begin
    irqFlags            = '0;
    irqFlags[irqRstBit] = flagRst;
    irqFlags[irqLpBit]  = flagLp;
  end

  assign irq = |(irqFlags & irqEnable);

  // only the raster and pen flags can raise irq
  irqSource: assert property (@(posedge clk25) disable iff (rst)
    irq |-> (flagRst && irqEnable[irqRstBit]) || (flagLp && irqEnable[irqLpBit]));
  // first hit per frame wins
  lpHold: assert property (@(posedge clk25) disable iff (rst)
    lpHit && $past(lpHit) |-> $stable(lpx) && $stable(lpy));

endmodule

`default_nettype wire

// File: verilog/colorOut.sv
// colour output stage
// black in blanking, exterior colour in the border, background inside
// registered colour split into 2-bit red, green and blue
`timescale 1ns/1ps
`default_nettype none

module colorOut
  import regMapPkg::*;
(
  input  wire                   clk25,
  input  wire                   rst,
  input  wire                   blank,
  input  wire                   border,
  input  wire  [colorWidth-1:0] extColor,
  input  wire  [colorWidth-1:0] bgColor,
  output logic [1:0]            red,
  output logic [1:0]            green,
  output logic [1:0]            blue
);

  logic [colorWidth-1:0] pixel;                      // selected this cycle
  logic [colorWidth-1:0] color;                      // output register

  // blank wins over border
  always_comb begin
    if (blank)
      pixel = '0;
    else if (border)
      pixel = extColor;
    else
      pixel = bgColor;
  end

  always_ff @(posedge clk25) begin
    if (rst)
      color <= '0;
    else
      color <= pixel;                                // one cycle after the flags
  end

  assign red   = color[5:4];
  assign green = color[3:2];
  assign blue  = color[1:0];

endmodule

`default_nettype wire

// File: verilog/videoTop.sv
// video controller top level
// raster timing, register block, interrupt unit and colour output
`timescale 1ns/1ps
`default_nettype none

module videoTop
  import timingPkg::*, regMapPkg::*;
(
  input  wire                     clk25,
  input  wire                     rst,
  input  wire                     cs,
  input  wire                     we,
  input  wire  [regAddrWidth-1:0] addr,
  input  wire  [7:0]              wrData,
  output wire  [7:0]              rdData,
  input  wire                     lpN,
  output wire                     irq,
  output wire                     hSync,
  output wire                     vSync,
  output wire  [1:0]              red,
  output wire  [1:0]              green,
  output wire  [1:0]              blue
);

  //------------------------------------------------------------
  // internal nets
  //------------------------------------------------------------
  wire [ctrWidth-1:0]   hCtr, vCtr;
  wire                  blank, border;
  wire [ctrWidth-1:0]   rasterCmp;
  wire [irqWidth-1:0]   irqEnable, irqFlags;
  wire                  rstClr, lpClr;
  wire [ctrWidth-1:0]   lpx, lpy;
  wire [colorWidth-1:0] extColor, bgColor;

  rasterTiming uTiming (
    .clk25(clk25), .rst(rst), .hCtr(hCtr), .vCtr(vCtr),
    .hSync(hSync), .vSync(vSync), .blank(blank), .border(border)
  );

  vicRegs uRegs (
    .clk25(clk25), .rst(rst), .cs(cs), .we(we), .addr(addr),
    .wrData(wrData), .rdData(rdData),
    .vCtr(vCtr), .irqFlags(irqFlags), .irq(irq), .lpx(lpx), .lpy(lpy),
    .rasterCmp(rasterCmp), .irqEnable(irqEnable), .rstClr(rstClr),
    .lpClr(lpClr), .extColor(extColor), .bgColor(bgColor)
  );

  interruptUnit uIrq (
    .clk25(clk25), .rst(rst), .hCtr(hCtr), .vCtr(vCtr),
    .rasterCmp(rasterCmp), .irqEnable(irqEnable), .rstClr(rstClr),
    .lpClr(lpClr), .lpN(lpN), .irqFlags(irqFlags), .irq(irq),
    .lpx(lpx), .lpy(lpy)
  );

  colorOut uColor (
    .clk25(clk25), .rst(rst), .blank(blank), .border(border),
    .extColor(extColor), .bgColor(bgColor),
    .red(red), .green(green), .blue(blue)
  );

endmodule

`default_nettype wire

// File: testbench/tbVideo.sv
// testbench for the video controller top level
// raster counter model, operation table applied in a loop
// compare task, per test report lines and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tbVideo
  import timingPkg::*, regMapPkg::*;
();

  localparam int frameCycles = 800 * 525;             // 525 lines of 800 clocks
  localparam int timeoutNs   = (3 * frameCycles + 4000) * 8;

  // table operations
  localparam logic [2:0] opWrite     = 3'd0;
  localparam logic [2:0] opRead      = 3'd1;          // fixed expected value
  localparam logic [2:0] opReadModel = 3'd2;          // expected from the model
  localparam logic [2:0] opWait      = 3'd3;
  localparam logic [2:0] opPen       = 3'd4;
  localparam logic [2:0] opSample    = 3'd5;

  typedef struct packed {
    logic [2:0]  op;
    logic [2:0]  test;
    logic [6:0]  addr;
    logic [11:0] h;
    logic [11:0] v;
    logic [7:0]  data;                                // write data, read value, irq
  } opEntry;

  logic       clk25  = 1'b0;
  logic       rst    = 1'b1;
  logic       cs     = 1'b0;
  logic       we     = 1'b0;
  logic [6:0] addr   = 7'd0;
  logic [7:0] wrData = 8'd0;
  logic       lpN    = 1'b1;                          // pen idle high
  wire  [7:0] rdData;
  wire        irq, hSync, vSync;
  wire  [1:0] red, green, blue;

  logic [11:0] mH = 12'd0, mV = 12'd0;                // counter model
  logic [11:0] pH1 = 12'd0, pV1 = 12'd0;              // one edge back for the flags
  logic [11:0] pH2 = 12'd0, pV2 = 12'd0;              // two edges back for rgb
  logic [11:0] penX = 12'd0, penY = 12'd0;
  logic        penTaken = 1'b0;
  logic [3:0]  vHiSh = 4'd0;                          // latched raster high bits
  logic [5:0]  extSh = 6'd0, bgSh = 6'd0;
  logic [2:0]  tblTest = 3'd1;
  opEntry      tbl[$];
  int          checks = 0;
  int          errors = 0;

  videoTop dut_i (
    .clk25(clk25), .rst(rst), .cs(cs), .we(we), .addr(addr), .wrData(wrData),
    .rdData(rdData), .lpN(lpN), .irq(irq), .hSync(hSync), .vSync(vSync),
    .red(red), .green(green), .blue(blue)
  );

  always #4 clk25 = ~clk25;                           // 8 ns period

  // model counters wrap to 1 at the totals
  always @(posedge clk25) begin
    pH2 = pH1;
    pV2 = pV1;
    pH1 = mH;
    pV1 = mV;
    if (rst) begin
      mH = 12'd0;
      mV = 12'd0;
    end else if (mH == hTotal) begin
      mH = 12'd1;
      mV = (mV == vTotal) ? 12'd1 : mV + 12'd1;
    end else
      mH = mH + 12'd1;
  end

  //------------------------------------------------------------
  // expected values
  //------------------------------------------------------------
  function automatic logic [5:0] colorAt(input logic [11:0] h, input logic [11:0] v);
    logic inBlank;
    logic inBorder;
    inBlank  = (h >= hTotal) || (h < hBlankOff) || (v >= vTotal) || (v < vBlankOff);
    inBorder = (h >= hBorderOn) || (h < hBorderOff) || (v >= vBorderOn) || (v < vBorderOff);
    if (inBlank)
      return 6'd0;
    else if (inBorder)
      return extSh;
    return bgSh;
  endfunction

  // sync is low inside its window
  function automatic logic syncAt(input logic [11:0] c, input logic [11:0] on,
                                  input logic [11:0] off);
    return (c >= on && c < off) ? 1'b0 : 1'b1;
  endfunction

  function automatic logic [7:0] modelRead(input logic [6:0] a);
    case (a)
      addrRasterLo: return mV[7:0];
      addrRasterHi: return {4'b0000, vHiSh};
      addrLpxLo:    return penX[7:0];
      addrLpxHi:    return {4'b0000, penX[11:8]};
      addrLpyLo:    return penY[7:0];
      addrLpyHi:    return {4'b0000, penY[11:8]};
      default:      return 8'hFF;
    endcase
  endfunction

  task automatic checkVal(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  //------------------------------------------------------------
  // table building
  //------------------------------------------------------------
  function automatic void addOp(input logic [2:0] op, input logic [6:0] a,
                                input logic [11:0] h, input logic [11:0] v,
                                input logic [7:0] d);
    tbl.push_back(opEntry'{op, tblTest, a, h, v, d});
  endfunction

  function automatic void addWrite(input logic [6:0] a, input logic [7:0] d);
    addOp(opWrite, a, 12'd0, 12'd0, d);
  endfunction

  function automatic void addRead(input logic [6:0] a, input logic [7:0] d);
    addOp(opRead, a, 12'd0, 12'd0, d);
  endfunction

  function automatic void addPenReads();
    addOp(opReadModel, addrLpxLo, 12'd0, 12'd0, 8'd0);
    addOp(opReadModel, addrLpxHi, 12'd0, 12'd0, 8'd0);
    addOp(opReadModel, addrLpyLo, 12'd0, 12'd0, 8'd0);
    addOp(opReadModel, addrLpyHi, 12'd0, 12'd0, 8'd0);
  endfunction

  // wait for the beam, then check rgb, syncs and irq
  function automatic void addSampleAt(input logic [11:0] h, input logic [11:0] v,
                                      input logic irqExp);
    addOp(opWait, 7'd0, h, v, 8'd0);
    addOp(opSample, 7'd0, 12'd0, 12'd0, {7'd0, irqExp});
  endfunction

  function automatic void addPenAt(input logic [11:0] h, input logic [11:0] v);
    addOp(opWait, 7'd0, h, v, 8'd0);
    addOp(opPen, 7'd0, 12'd0, 12'd0, 8'd0);
  endfunction

  function automatic void buildTable();
    tblTest = 3'd1;                                   // reset values, read-back
    addOp(opReadModel, addrRasterLo, 12'd0, 12'd0, 8'd0);
    addOp(opReadModel, addrRasterHi, 12'd0, 12'd0, 8'd0);
    addPenReads();
    addRead(addrIrqStat, 8'h70);
    addRead(addrIrqEn, 8'h00);
    addRead(addrExtColor, 8'h00);
    addRead(addrBgColor, 8'h00);
    addWrite(addrExtColor, 8'hFF);
    addRead(addrExtColor, 8'h3F);                     // six bits stored
    addWrite(addrExtColor, 8'h2D);
    addRead(addrExtColor, 8'h2D);
    addWrite(addrBgColor, 8'h12);
    addRead(addrBgColor, 8'h12);
    addWrite(addrIrqEn, 8'h09);
    addRead(addrIrqEn, 8'h09);
    addWrite(addrIrqEn, 8'h00);
    addRead(7'h10, 8'hFF);
    addRead(7'h64, 8'hFF);
    tblTest = 3'd2;                                   // sync and colour
    addSampleAt(12'd50, 12'd11, 1'b0);                // inside both sync windows
    addSampleAt(12'd100, 12'd20, 1'b0);
    addSampleAt(12'd164, 12'd47, 1'b0);
    addSampleAt(12'd167, 12'd100, 1'b0);
    addSampleAt(12'd300, 12'd100, 1'b0);
    addSampleAt(12'd2, 12'd101, 1'b0);                // across the line wrap
    addSampleAt(12'd300, 12'd522, 1'b0);
    addOp(opReadModel, addrRasterLo, 12'd0, 12'd0, 8'd0);  // line above 511
    addOp(opReadModel, addrRasterHi, 12'd0, 12'd0, 8'd0);
    tblTest = 3'd3;                                   // raster interrupt
    addWrite(addrRasterLo, 8'd60);
    addWrite(addrRasterHi, 8'd0);
    addWrite(addrIrqEn, 8'h01);
    addSampleAt(12'd300, 12'd59, 1'b0);
    addSampleAt(12'd5, 12'd60, 1'b1);
    addRead(addrIrqStat, 8'hF1);
    addWrite(addrIrqStat, 8'h01);
    addSampleAt(12'd300, 12'd60, 1'b0);
    addRead(addrIrqStat, 8'h70);
    addSampleAt(12'd300, 12'd400, 1'b0);
    addSampleAt(12'd300, 12'd520, 1'b0);
    addSampleAt(12'd300, 12'd60, 1'b1);               // next frame
    addRead(addrIrqStat, 8'hF1);
    addWrite(addrIrqStat, 8'h01);
    addRead(addrIrqStat, 8'h70);
    tblTest = 3'd4;                                   // light pen
    addPenAt(12'd400, 12'd200);
    addPenReads();
    addPenAt(12'd500, 12'd300);                       // second hit ignored
    addPenReads();
    tblTest = 3'd5;                                   // mask and clear
    addSampleAt(12'd600, 12'd300, 1'b0);
    addRead(addrIrqStat, 8'h78);
    addWrite(addrIrqEn, 8'h08);
    addRead(addrIrqStat, 8'hF8);
    addSampleAt(12'd700, 12'd300, 1'b1);
    addWrite(addrIrqStat, 8'h08);
    addRead(addrIrqStat, 8'h70);
    addSampleAt(12'd300, 12'd301, 1'b0);
  endfunction

  //------------------------------------------------------------
  // operation driver
  //------------------------------------------------------------
  // each operation starts and ends 1 ns after an edge
  task automatic runOp(input opEntry e);
    logic [7:0] expData;
    case (e.op)
      opWrite: begin
        cs = 1'b1;
        we = 1'b1;
        addr = e.addr;
        wrData = e.data;
        @(posedge clk25);
        #1;
        cs = 1'b0;
        we = 1'b0;
        if (e.addr == addrExtColor) extSh = e.data[5:0];
        if (e.addr == addrBgColor) bgSh = e.data[5:0];
        repeat (2) @(posedge clk25);                  // clear strobe reaches the flags
        #1;
      end
      opRead, opReadModel: begin
        expData = (e.op == opRead) ? e.data : modelRead(e.addr);
        if (e.addr == addrRasterLo) vHiSh = mV[11:8];
        cs = 1'b1;
        we = 1'b0;
        addr = e.addr;
        @(posedge clk25);
        #1;
        cs = 1'b0;
        checkVal(rdData, expData, $sformatf("read of %h", e.addr));
      end
      opWait: begin
        while (mH != e.h || mV != e.v) begin
          @(posedge clk25);
          #1;
        end
      end
      opPen: begin
        if (!penTaken && mV != 12'd0) begin           // first hit latches the beam
          penX = mH;
          penY = mV;
          penTaken = 1'b1;
        end
        lpN = 1'b0;
        @(posedge clk25);
        #1;
        lpN = 1'b1;
      end
      opSample: begin
        checkVal({2'b00, red, green, blue}, {2'b00, colorAt(pH2, pV2)}, "rgb");
        checkVal({7'd0, hSync}, {7'd0, syncAt(pH1, hSyncOn, hSyncOff)}, "hSync");
        checkVal({7'd0, vSync}, {7'd0, syncAt(pV1, vSyncOn, vSyncOff)}, "vSync");
        checkVal({7'd0, irq}, {7'd0, e.data[0]}, "irq");
      end
      default: ;
    endcase
  endtask

  task automatic reportTest(input logic [2:0] n, input int errs);
    string name;
    string verdict;
    case (n)
      3'd1:    name = "register read-back";
      3'd2:    name = "sync and colour";
      3'd3:    name = "raster interrupt";
      3'd4:    name = "light pen";
      default: name = "mask and clear";
    endcase
    if (errs == 0)
      verdict = "ok";
    else
      verdict = "failed";
    $display("test %0d %s: %s, %0d errors", n, name, verdict, errs);
  endtask

  initial begin
    logic [2:0] curTest;
    int         errBase;
    buildTable();
    repeat (3) @(posedge clk25);
    #1 rst = 1'b0;
    curTest = 3'd1;
    errBase = 0;
    foreach (tbl[i]) begin
      if (tbl[i].test != curTest) begin
        reportTest(curTest, errors - errBase);
        curTest = tbl[i].test;
        errBase = errors;
      end
      runOp(tbl[i]);
    end
    reportTest(curTest, errors - errBase);
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // three frames plus margin
  initial begin
    #(timeoutNs);
    $display("watchdog expired after %0d ns, the table did not complete", timeoutNs);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/timingPkg.sv
verilog/regMapPkg.sv
verilog/rasterTiming.sv
verilog/vicRegs.sv
verilog/interruptUnit.sv
verilog/colorOut.sv
verilog/videoTop.sv
testbench/tbVideo.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbVideo \
  -f src.f -o simVideo &&
./obj_dir/simVideo > sim.log 2>&1 || {
  cat sim.log 2>/dev/null
  echo "build or simulation error"
  exit 1
}
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
